//--- vlog.f
hw/coreTypes.sv
hw/forwardCtrl.sv
hw/regFile.sv
hw/fetchDecode.sv
hw/executeStage.sv
hw/memWriteback.sv
hw/riscCore.sv
tests/clockGen.sv
tests/coreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module coreTb -f vlog.f -o coreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tests/coreTb.sv
module coreTb;
    logic clk, rstGen, rerun, rst, stall, stallEn, checking;
    logic [31:0] imemAddr, imemData, dmemData;
    coreTypes::dmemReqT dmemReq;
    logic [31:0] prog [256];
    logic [31:0] dmem [1024];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] rngState;
    int progLen, storeOff, seen, edgesSinceRst, valueErrors, otherErrors;
    string testName;

    clockGen clkGen (.clk(clk), .rst(rstGen));

    assign rst = rstGen || rerun; // Second run needs its own reset

    riscCore dut (
        .clk, .rst, .stall,
        .imemAddr, .imemData,
        .dmemReq, .dmemData
    );

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // Background word unique to each data memory index
    function automatic logic [31:0] dataFill(int idx);
        return {16'hc0de ^ idx[15:0], ~idx[15:0]};
    endfunction

    // Memory models with one cycle of read latency that freeze under stall
    always @(posedge clk) begin
        if (!stall) begin
            imemData <= prog[imemAddr[9:2]];
            if (dmemReq.we) dmem[dmemReq.addr[11:2]] <= dmemReq.wdata;
            if (dmemReq.re) dmemData <= dmem[dmemReq.addr[11:2]];
        end
    end

    always @(negedge clk) begin
        stall <= stallEn && (nextRand() % 32'd4 == 32'd0); // About one cycle in four
    end

    function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd, logic [6:0] op);
        coreTypes::instrU w;
        w.r = '{funct7: f7[6:0], rs2: rs2[4:0], rs1: rs1[4:0], funct3: f3[2:0],
                rd: rd[4:0], opcode: op};
        return w;
    endfunction

    function automatic logic [31:0] encI(int imm, int rs1, int f3, int rd, logic [6:0] op);
        coreTypes::instrU w;
        w.i = '{imm11to0: imm[11:0], rs1: rs1[4:0], funct3: f3[2:0], rd: rd[4:0], opcode: op};
        return w;
    endfunction

    function automatic logic [31:0] encS(int imm, int rs2, int rs1);
        coreTypes::instrU w;
        w.s = '{imm11to5: imm[11:5], rs2: rs2[4:0], rs1: rs1[4:0], funct3: 3'b010,
                imm4to0: imm[4:0], opcode: coreTypes::opStore};
        return w;
    endfunction

    function automatic logic [31:0] encB(int imm, int rs2, int rs1, int f3);
        coreTypes::instrU w;
        w.b = '{imm12: imm[12], imm10to5: imm[10:5], rs2: rs2[4:0], rs1: rs1[4:0],
                funct3: f3[2:0], imm4to1: imm[4:1], imm11: imm[11],
                opcode: coreTypes::opBranch};
        return w;
    endfunction

    function automatic logic [31:0] encJ(int imm, int rd);
        coreTypes::instrU w;
        w.j = '{imm20: imm[20], imm10to1: imm[10:1], imm11: imm[11], imm19to12: imm[19:12],
                rd: rd[4:0], opcode: coreTypes::opJal};
        return w;
    endfunction

    task automatic emit(logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic storeReg(int rs); // Store to the next result slot above x10
        emit(encS(storeOff, rs, 10));
        storeOff += 4;
    endtask

    task automatic loadConst(int rd, logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12; // Compensates the sign of the low part
        emit({upper[19:0], rd[4:0], coreTypes::opLui});
        emit(encI(int'(v[11:0]), rd, 0, rd, coreTypes::opOpImm));
    endtask

    task automatic buildProgram();
        int f3, r1, r2;
        logic [31:0] v;
        progLen = 0;
        storeOff = 0;
        // Nops tagged with their own index
        for (int i = 0; i < 256; i++) prog[i] = encI(i, 0, 0, 0, coreTypes::opOpImm);
        emit(encI(12'h400, 0, 0, 10, coreTypes::opOpImm)); // Data base
        for (int r = 1; r <= 5; r++) loadConst(r, nextRand());
        for (int f = 0; f < 8; f++) begin // Register forms including SUB and SRA
            emit(encR(0, 2, 1, f, 6, coreTypes::opOp));
            storeReg(6);
            if (f == 0 || f == 5) begin
                emit(encR(32, 2, 1, f, 6, coreTypes::opOp));
                storeReg(6);
            end
        end
        for (int f = 0; f < 8; f++) begin // Immediate forms
            v = nextRand();
            if (f == 1 || f == 5) v = {20'b0, 7'b0, v[4:0]}; // Shift amount only
            emit(encI(int'(v[11:0]), 3, f, 6, coreTypes::opOpImm));
            storeReg(6);
            if (f == 5) begin
                emit(encI(int'({7'b0100000, v[4:0]}), 3, f, 6, coreTypes::opOpImm));
                storeReg(6);
            end
        end
        v = nextRand();
        emit({v[19:0], 5'd6, coreTypes::opLui});
        storeReg(6);
        for (int d = 1; d <= 3; d++) begin // Dependence distance d
            emit(encR(0, 2, 1, 0, 7, coreTypes::opOp));
            for (int k = 1; k < d; k++) emit(encI(1, 12, 0, 12, coreTypes::opOpImm));
            emit(encR(0, 3, 7, 4, 8, coreTypes::opOp));
            storeReg(8);
        end
        storeReg(4); // Load use as ALU source
        emit(encI(storeOff - 4, 10, 2, 13, coreTypes::opLoad));
        emit(encR(0, 1, 13, 0, 14, coreTypes::opOp));
        storeReg(14);
        emit(encI(storeOff - 4, 10, 2, 13, coreTypes::opLoad)); // As store data
        storeReg(13);
        emit(encI(storeOff + 4, 10, 0, 15, coreTypes::opOpImm)); // As store base
        storeReg(15);
        emit(encI(storeOff - 4, 10, 2, 16, coreTypes::opLoad));
        emit(encS(0, 3, 16));
        storeOff += 4;
        for (int b = 0; b < 12; b++) begin // Branches skip one store when taken
            f3 = (nextRand() % 32'd4 > 32'd1) ? int'(nextRand() % 32'd2) + 4
                                                 : int'(nextRand() % 32'd2);
            r1 = int'(nextRand() % 32'd4) - 2;
            r2 = int'(nextRand() % 32'd4) - 2;
            emit(encI(r1, 0, 0, 17, coreTypes::opOpImm));
            emit(encI(r2, 0, 0, 18, coreTypes::opOpImm));
            emit(encB(8, 18, 17, f3));
            storeReg(1);
        end
        emit(encJ(8, 19)); // Jump over a store
        storeReg(1);
        storeReg(19);
        emit(encJ(0, 0)); // Park here
    endtask

    function automatic logic [31:0] aluRef(int f3, logic alt, logic [31:0] a, logic [31:0] b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: return (a < b) ? 32'd1 : 32'd0;
            4: return a ^ b;
            5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA level model that fills the expected store list
    function automatic void runReference();
        logic [31:0] r [32];
        logic [31:0] dm [int];
        logic [31:0] pcR, a, b, addr;
        logic [31:0] immI, immS, immB, immJ;
        logic cond;
        coreTypes::instrU w;
        pcR = '0;
        for (int i = 0; i < 32; i++) r[i] = '0;
        expAddr.delete();
        expData.delete();
        for (int step = 0; step < 2000; step++) begin
            w = prog[pcR[9:2]];
            if (w == encJ(0, 0)) break;
            a = r[w.r.rs1];
            b = r[w.r.rs2];
            immI = {{20{w.i.imm11to0[11]}}, w.i.imm11to0};
            immS = {{20{w.s.imm11to5[6]}}, w.s.imm11to5, w.s.imm4to0};
            immB = {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10to5, w.b.imm4to1, 1'b0};
            immJ = {{11{w.j.imm20}}, w.j.imm20, w.j.imm19to12, w.j.imm11, w.j.imm10to1, 1'b0};
            case (w.r.opcode)
                coreTypes::opLui: r[w.r.rd] = {w.u.imm31to12, 12'b0};
                coreTypes::opOp:
                    r[w.r.rd] = aluRef(int'(w.r.funct3), w.r.funct7[5], a, b);
                coreTypes::opOpImm:
                    r[w.r.rd] = aluRef(int'(w.r.funct3),
                                       w.r.funct3 == 3'd5 && w.r.funct7[5], a, immI);
                coreTypes::opLoad: begin
                    addr = a + immI;
                    r[w.r.rd] = dm.exists(int'(addr)) ? dm[int'(addr)]
                                                      : dataFill(int'(addr[11:2]));
                end
                coreTypes::opStore: begin
                    addr = a + immS;
                    dm[int'(addr)] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                default: ;
            endcase
            r[0] = '0;
            if (w.r.opcode == coreTypes::opJal) begin
                if (w.r.rd != 5'd0) r[w.r.rd] = pcR + 32'd4;
                pcR = pcR + immJ;
            end else if (w.r.opcode == coreTypes::opBranch) begin
                case (w.b.funct3)
                    3'd0: cond = a == b;
                    3'd1: cond = a != b;
                    3'd4: cond = $signed(a) < $signed(b);
                    default: cond = $signed(a) >= $signed(b);
                endcase
                pcR = cond ? pcR + immB : pcR + 32'd4;
            end else begin
                pcR = pcR + 32'd4;
            end
        end
    endfunction

    // Store compare on every unstalled edge
    always @(posedge clk) begin
        if (rst) begin
            edgesSinceRst <= 0;
        end else if (!stall) begin
            edgesSinceRst <= edgesSinceRst + 1;
            if (edgesSinceRst < 2 && (dmemReq.re || dmemReq.we)) begin
                $display("Memory strobe raised before the first instruction reached X (%s)",
                         testName);
                otherErrors++;
            end
            if (checking && dmemReq.we) begin
                if (seen >= expAddr.size()) begin
                    $display("Unexpected extra store to %h in %s", dmemReq.addr, testName);
                    otherErrors++;
                end else begin
                    if (dmemReq.addr != expAddr[seen]) begin
                        $display("CHECK FAILED %s store %0d addr expected %h actual %h",
                                 testName, seen, expAddr[seen], dmemReq.addr);
                        valueErrors++;
                    end
                    if (dmemReq.wdata != expData[seen]) begin
                        $display("CHECK FAILED %s store %0d data expected %h actual %h",
                                 testName, seen, expData[seen], dmemReq.wdata);
                        valueErrors++;
                    end
                end
                seen++;
            end
        end
    end

    task automatic runProgram(string name);
        int cycles;
        testName = name;
        cycles = 0;
        while (rst && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (rst) begin
            $display("Reset never released in %s", name);
            otherErrors++;
        end
        cycles = 0;
        while (seen < expAddr.size() && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (seen < expAddr.size()) begin
            $display("Timeout in %s, only %0d of %0d stores seen", name, seen, expAddr.size());
            otherErrors++;
        end
        repeat (40) @(negedge clk); // Window for stray stores
        checking = 1'b0;
    endtask

    initial begin
        stall = 1'b0;
        stallEn = 1'b0;
        rerun = 1'b0;
        imemData = '0;
        dmemData = '0;
        checking = 1'b1;
        seen = 0;
        valueErrors = 0;
        otherErrors = 0;
        testName = "noStall";
        rngState = 32'd5;
        for (int i = 0; i < 1024; i++) dmem[i] = dataFill(i);
        buildProgram();
        runReference();
        runProgram("noStall");
        @(negedge clk);
        rerun = 1'b1;
        stallEn = 1'b1;
        for (int i = 0; i < 1024; i++) dmem[i] = dataFill(i);
        seen = 0;
        checking = 1'b1;
        testName = "randomStall";
        repeat (5) @(negedge clk);
        rerun = 1'b0;
        runProgram("randomStall");
        $display("expected stores %0d per run, value errors %0d, other errors %0d",
                 expAddr.size(), valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end
endmodule

//--- tests/clockGen.sv
module clockGen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // Period 4
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk); // Five cycles of reset
        @(negedge clk);
        rst = 1'b0;
    end
endmodule

//--- hw/riscCore.sv
module riscCore (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             stall,
    output logic [coreTypes::xlen-1:0]       imemAddr,
    input  logic [31:0]                      imemData,
    output coreTypes::dmemReqT               dmemReq,
    input  logic [coreTypes::xlen-1:0]       dmemData
);
    coreTypes::fdToXT fdToX;
    coreTypes::xToMT xToM;
    coreTypes::instrU decodeInst, instX, instM, instW;
    coreTypes::fwdSelT fwdA, fwdB;

    logic [4:0] rs1Idx, rs2Idx, rdIdx;
    logic rdWen;
    logic redirect;
    logic [coreTypes::xlen-1:0] rs1Data, rs2Data;
    logic [coreTypes::xlen-1:0] aluX, linkX, aluM, loadM, linkM, wbValue;
    logic [coreTypes::xlen-1:0] redirectPc;

    fetchDecode fd (
        .clk, .rst, .stall,
        .imemData, .imemAddr,
        .rs1Data, .rs2Data, .rs1Idx, .rs2Idx,
        .fwdA, .fwdB,
        .aluX, .linkX, .aluM, .loadM, .linkM, .wbValue,
        .redirect, .redirectPc,
        .fdToX, .decodeInst
    );

    forwardCtrl fwd (
        .decodeInst, .instX, .instM, .instW,
        .fwdA, .fwdB
    );

    regFile rf (
        .clk, .rst, .stall,
        .rs1Idx, .rs2Idx, .rdIdx,
        .rdWen, .rdData(wbValue),
        .rs1Data, .rs2Data
    );

    executeStage ex (
        .clk, .rst, .stall,
        .fdToX, .instM, .loadM,
        .aluX, .linkX,
        .redirect, .redirectPc,
        .dmemReq, .xToM, .instX
    );

    memWriteback mw (
        .clk, .rst, .stall,
        .xToM, .dmemData,
        .loadM, .aluM, .linkM,
        .instM, .instW,
        .rdIdx, .rdWen, .wbValue
    );

endmodule

//--- hw/memWriteback.sv
module memWriteback (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  coreTypes::xToMT            xToM,
    input  logic [coreTypes::xlen-1:0] dmemData,
    output logic [coreTypes::xlen-1:0] loadM,
    output logic [coreTypes::xlen-1:0] aluM,
    output logic [coreTypes::xlen-1:0] linkM,
    output coreTypes::instrU           instM,
    output coreTypes::instrU           instW,
    output logic [4:0]                 rdIdx,
    output logic                       rdWen,
    output logic [coreTypes::xlen-1:0] wbValue
);
    coreTypes::mToWT mToW;

    // M stage view
    assign instM = xToM.inst;
    assign aluM  = xToM.alu;
    assign linkM = xToM.link;
    assign loadM = dmemData; // Read data arrives the cycle after the request

    always_ff @(posedge clk) begin
        if (rst) begin
            mToW.inst <= coreTypes::nopWord;
        end else if (!stall) begin
            mToW <= '{inst: xToM.inst, alu: xToM.alu, load: dmemData, link: xToM.link};
        end
    end

    assign instW = mToW.inst;
    assign rdIdx = mToW.inst.r.rd;
    assign rdWen = coreTypes::writesRd(mToW.inst);

    // Writeback source by opcode
    always_comb begin
        case (mToW.inst.r.opcode)
            coreTypes::opLoad: wbValue = mToW.load;
            coreTypes::opJal:  wbValue = mToW.link;
            default:           wbValue = mToW.alu;
        endcase
    end

    // Load data must hold while a stalled load waits in M
    loadHeldOnStall: assert property (@(posedge clk) disable iff (rst)
        stall && instM.r.opcode == coreTypes::opLoad |=> $stable(dmemData));

endmodule

//--- hw/executeStage.sv
module executeStage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  coreTypes::fdToXT           fdToX,
    input  coreTypes::instrU           instM,
    input  logic [coreTypes::xlen-1:0] loadM,
    output logic [coreTypes::xlen-1:0] aluX,
    output logic [coreTypes::xlen-1:0] linkX,
    output logic                       redirect,
    output logic [coreTypes::xlen-1:0] redirectPc,
    output coreTypes::dmemReqT         dmemReq,
    output coreTypes::xToMT            xToM,
    output coreTypes::instrU           instX
);
    coreTypes::instrU inst;
    coreTypes::aluOpT aluOp;
    logic loadInM;
    logic [coreTypes::xlen-1:0] opA, opB; // After late load forward
    logic [coreTypes::xlen-1:0] aluB;
    logic [coreTypes::xlen-1:0] aluRes;
    logic taken;

    assign inst = fdToX.inst;
    assign instX = inst;

    // Load one stage ahead substitutes its data directly
    assign loadInM = (instM.r.opcode == coreTypes::opLoad) && (instM.r.rd != 5'd0);
    assign opA = (loadInM && instM.r.rd == inst.r.rs1) ? loadM : fdToX.opA;
    assign opB = (loadInM && instM.r.rd == inst.r.rs2) ? loadM : fdToX.opB;

    // ALU control
    always_comb begin
        aluOp = coreTypes::aluAdd; // Loads, stores, JAL
        case (inst.r.opcode)
            coreTypes::opLui: aluOp = coreTypes::aluPassB;
            coreTypes::opOp, coreTypes::opOpImm: begin
                case (inst.r.funct3)
                    3'b000: aluOp = (inst.r.opcode == coreTypes::opOp && inst.r.funct7[5])
                                    ? coreTypes::aluSub : coreTypes::aluAdd;
                    3'b001: aluOp = coreTypes::aluSll;
                    3'b010: aluOp = coreTypes::aluSlt;
                    3'b011: aluOp = coreTypes::aluSltu;
                    3'b100: aluOp = coreTypes::aluXor;
                    3'b101: aluOp = inst.r.funct7[5] ? coreTypes::aluSra : coreTypes::aluSrl;
                    3'b110: aluOp = coreTypes::aluOr;
                    default: aluOp = coreTypes::aluAnd;
                endcase
            end
            default: aluOp = coreTypes::aluAdd;
        endcase
    end

    assign aluB = (inst.r.opcode == coreTypes::opOp) ? opB : fdToX.imm;

    always_comb begin
        case (aluOp)
            coreTypes::aluSub:   aluRes = opA - aluB;
            coreTypes::aluSll:   aluRes = opA << aluB[4:0];
            coreTypes::aluSlt:   aluRes = {31'b0, $signed(opA) < $signed(aluB)};
            coreTypes::aluSltu:  aluRes = {31'b0, opA < aluB};
            coreTypes::aluXor:   aluRes = opA ^ aluB;
            coreTypes::aluSrl:   aluRes = opA >> aluB[4:0];
            coreTypes::aluSra:   aluRes = $unsigned($signed(opA) >>> aluB[4:0]);
            coreTypes::aluOr:    aluRes = opA | aluB;
            coreTypes::aluAnd:   aluRes = opA & aluB;
            coreTypes::aluPassB: aluRes = aluB; // LUI
            default:             aluRes = opA + aluB;
        endcase
    end

    assign aluX = aluRes;
    assign linkX = fdToX.pc + 32'd4;

    // Branches are predicted not taken
    always_comb begin
        case (inst.b.funct3)
            3'b000:  taken = opA == opB; // BEQ
            3'b001:  taken = opA != opB; // BNE
            3'b100:  taken = $signed(opA) < $signed(opB); // BLT
            3'b101:  taken = $signed(opA) >= $signed(opB); // BGE
            default: taken = 1'b0;
        endcase
    end

    assign redirect = (inst.r.opcode == coreTypes::opBranch) && taken;
    assign redirectPc = fdToX.pc + fdToX.imm;

    // Memory request addressed by the ALU sum
    assign dmemReq.addr  = aluRes;
    assign dmemReq.wdata = opB;
    assign dmemReq.re    = inst.r.opcode == coreTypes::opLoad;
    assign dmemReq.we    = inst.r.opcode == coreTypes::opStore;

    always_ff @(posedge clk) begin
        if (rst) begin
            xToM.inst <= coreTypes::nopWord;
        end else if (!stall) begin
            xToM <= '{inst: inst, alu: aluRes, link: linkX};
        end
    end

    // Request held steady while the memory is stalled
    reqHeldOnStall: assert property (
        @(posedge clk) disable iff (rst) stall |=> $stable(dmemReq));

endmodule

//--- hw/fetchDecode.sv
module fetchDecode (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  logic [31:0]                imemData,
    output logic [coreTypes::xlen-1:0] imemAddr,
    input  logic [coreTypes::xlen-1:0] rs1Data,
    input  logic [coreTypes::xlen-1:0] rs2Data,
    output logic [4:0]                 rs1Idx,
    output logic [4:0]                 rs2Idx,
    input  coreTypes::fwdSelT          fwdA,
    input  coreTypes::fwdSelT          fwdB,
    input  logic [coreTypes::xlen-1:0] aluX,
    input  logic [coreTypes::xlen-1:0] linkX,
    input  logic [coreTypes::xlen-1:0] aluM,
    input  logic [coreTypes::xlen-1:0] loadM,
    input  logic [coreTypes::xlen-1:0] linkM,
    input  logic [coreTypes::xlen-1:0] wbValue,
    input  logic                       redirect,
    input  logic [coreTypes::xlen-1:0] redirectPc,
    output coreTypes::fdToXT           fdToX,
    output coreTypes::instrU           decodeInst
);
    logic [coreTypes::xlen-1:0] pc; // Address of the word in decode
    logic [coreTypes::xlen-1:0] nextPc;
    logic [coreTypes::xlen-1:0] imm;
    logic primed; // Low until the first fetch after reset has landed
    coreTypes::instrU inst;
    coreTypes::fdToXT fdNext;

    // Pick an operand from the register file or a later stage
    function automatic logic [coreTypes::xlen-1:0] pickOperand(
        coreTypes::fwdSelT sel,
        logic [coreTypes::xlen-1:0] rfVal
    );
        case (sel)
            coreTypes::fwdAluX:  return aluX;
            coreTypes::fwdAluM:  return aluM;
            coreTypes::fwdLoadM: return loadM;
            coreTypes::fwdLinkX: return linkX;
            coreTypes::fwdLinkM: return linkM;
            coreTypes::fwdWb:    return wbValue;
            default:             return rfVal;
        endcase
    endfunction

    assign inst = primed ? imemData : coreTypes::nopWord; // Stale word before first fetch
    assign decodeInst = inst;
    assign rs1Idx = inst.r.rs1;
    assign rs2Idx = inst.r.rs2;

    // Immediate by format
    always_comb begin
        case (inst.r.opcode)
            coreTypes::opStore:
                imm = {{20{inst.s.imm11to5[6]}}, inst.s.imm11to5, inst.s.imm4to0};
            coreTypes::opBranch:
                imm = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10to5,
                       inst.b.imm4to1, 1'b0};
            coreTypes::opLui:
                imm = {inst.u.imm31to12, 12'b0};
            coreTypes::opJal:
                imm = {{12{inst.j.imm20}}, inst.j.imm19to12, inst.j.imm11,
                       inst.j.imm10to1, 1'b0};
            default:
                imm = {{20{inst.i.imm11to0[11]}}, inst.i.imm11to0}; // I-type and nop
        endcase
    end

    // Next fetch address
    always_comb begin
        if (redirect) begin
            nextPc = redirectPc; // Taken branch in X wins
        end else if (!primed) begin
            nextPc = pc; // Refetch reset address
        end else if (inst.r.opcode == coreTypes::opJal) begin
            nextPc = pc + imm; // JAL resolves here
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    assign imemAddr = nextPc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= coreTypes::resetPc;
            primed <= 1'b0;
        end else if (!stall) begin
            pc <= nextPc;
            primed <= 1'b1;
        end
    end

    always_comb begin
        fdNext.inst = redirect ? coreTypes::nopWord : inst; // Squash wrong-path word
        fdNext.pc   = pc;
        fdNext.imm  = imm;
        fdNext.opA  = pickOperand(fwdA, rs1Data);
        fdNext.opB  = pickOperand(fwdB, rs2Data);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fdToX.inst <= coreTypes::nopWord;
        end else if (!stall) begin
            fdToX <= fdNext;
        end
    end

    // Branch and jump targets keep fetch word aligned
    pcAligned: assert property (@(posedge clk) disable iff (rst) imemAddr[1:0] == 2'b00);

endmodule

//--- hw/regFile.sv
module regFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  logic [4:0]                 rs1Idx,
    input  logic [4:0]                 rs2Idx,
    input  logic [4:0]                 rdIdx,
    input  logic                       rdWen,
    input  logic [coreTypes::xlen-1:0] rdData,
    output logic [coreTypes::xlen-1:0] rs1Data,
    output logic [coreTypes::xlen-1:0] rs2Data
);
    logic [coreTypes::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (!stall && rdWen && rdIdx != 5'd0) begin
            regs[rdIdx] <= rdData; // x0 stays zero
        end
    end

    // Combinational reads
    assign rs1Data = regs[rs1Idx];
    assign rs2Data = regs[rs2Idx];

endmodule

//--- hw/forwardCtrl.sv
module forwardCtrl (
    input  coreTypes::instrU  decodeInst,
    input  coreTypes::instrU  instX,
    input  coreTypes::instrU  instM,
    input  coreTypes::instrU  instW,
    output coreTypes::fwdSelT fwdA,
    output coreTypes::fwdSelT fwdB
);
    // Youngest producer of rs wins
    function automatic coreTypes::fwdSelT pickSource(
        logic [4:0] rs,
        coreTypes::instrU x,
        coreTypes::instrU m,
        coreTypes::instrU w
    );
        if (rs == 5'd0) begin
            return coreTypes::fwdRf; // x0 never forwarded
        end else if (coreTypes::writesRd(x) && x.r.rd == rs) begin
            if (x.r.opcode == coreTypes::opJal) begin
                return coreTypes::fwdLinkX;
            end else if (x.r.opcode == coreTypes::opLoad) begin
                return coreTypes::fwdRf; // Load data not back yet, late path in X covers it
            end
            return coreTypes::fwdAluX;
        end else if (coreTypes::writesRd(m) && m.r.rd == rs) begin
            if (m.r.opcode == coreTypes::opJal) begin
                return coreTypes::fwdLinkM;
            end else if (m.r.opcode == coreTypes::opLoad) begin
                return coreTypes::fwdLoadM;
            end
            return coreTypes::fwdAluM;
        end else if (coreTypes::writesRd(w) && w.r.rd == rs) begin
            return coreTypes::fwdWb; // Register file write lands at the next edge
        end
        return coreTypes::fwdRf;
    endfunction

    assign fwdA = pickSource(decodeInst.r.rs1, instX, instM, instW);
    assign fwdB = pickSource(decodeInst.r.rs2, instX, instM, instW);

endmodule

//--- hw/coreTypes.sv
package coreTypes;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] resetPc = '0; // First fetch address
    localparam logic [31:0] nopWord = 32'h0000_0013; // addi x0, x0, 0

    // Major opcodes kept by this core
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd,
        aluPassB // LUI
    } aluOpT;

    // Decode operand sources
    typedef enum logic [2:0] {
        fwdRf, fwdAluX, fwdAluM, fwdLoadM, fwdLinkX, fwdLinkM, fwdWb
    } fwdSelT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0] imm11to0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmtT;

    typedef struct packed {
        logic [6:0] imm11to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4to0;
        logic [6:0] opcode;
    } sFmtT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFmtT;

    typedef struct packed {
        logic [19:0] imm31to12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFmtT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFmtT;

    // Same word seen through every format
    typedef union packed {
        rFmtT r;
        iFmtT i;
        sFmtT s;
        bFmtT b;
        uFmtT u;
        jFmtT j;
    } instrU;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            re;
        logic            we;
    } dmemReqT;

    typedef struct packed {
        instrU           inst;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] opA;
        logic [xlen-1:0] opB;
    } fdToXT;

    typedef struct packed {
        instrU           inst;
        logic [xlen-1:0] alu;
        logic [xlen-1:0] link; // PC+4
    } xToMT;

    typedef struct packed {
        instrU           inst;
        logic [xlen-1:0] alu;
        logic [xlen-1:0] load;
        logic [xlen-1:0] link;
    } mToWT;

    // True when the instruction writes a register other than x0
    function automatic logic writesRd(instrU inst);
        return (inst.r.rd != 5'd0) &&
               (inst.r.opcode inside {opLoad, opJal, opLui, opOpImm, opOp});
    endfunction

endpackage
